// ==== files.f ====
axi_bridge_pkg.sv
rd_port.sv
wr_burst_fsm.sv
beat_counter.sv
wr_port.sv
cnn_axi_bridge.sv
tb_cnn_axi_bridge.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --timescale 1ns/1ps -f files.f \
    --top-module tb_cnn_axi_bridge -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== tb_cnn_axi_bridge.sv ====
`timescale 1ns/1ps

module tb_cnn_axi_bridge;

    localparam int NR      = 2;   // Read clients
    localparam int NW      = 2;   // Write clients
    localparam int NE      = 8;   // Table entries (reset check uses slot NE)
    localparam int TIMEOUT = 200; // Cycles per wait
    localparam int IW = axi_bridge_pkg::ID_W;
    localparam int AW = axi_bridge_pkg::ADDR_W;
    localparam int LW = axi_bridge_pkg::LEN_W;
    localparam int DW = axi_bridge_pkg::DATA_W;
    localparam int SW = axi_bridge_pkg::STRB_W;
    localparam int ZW = axi_bridge_pkg::SIZE_W;
    localparam int BW = axi_bridge_pkg::BURST_W;

    typedef struct {
        string          name;
        logic           is_wr;  // Set for a write
        int             client;
        logic [IW-1:0]  id;
        logic [AW-1:0]  addr;
        logic [LW-1:0]  len;    // Beats minus one
        logic [DW-1:0]  seed;   // Beat k carries seed + k
    } entry_t;

    logic clk;
    logic rst;
    logic [NR-1:0]    rd_req, rd_req_ack, rd_data_vld, rd_data_rdy, rd_cmpl;
    logic [NR-1:0]    arready, arvalid, rlast, rvalid, rready;
    logic [NR*IW-1:0] rd_req_id, arid;
    logic [NR*AW-1:0] rd_addr, araddr;
    logic [NR*LW-1:0] rd_len, arlen;
    logic [NR*DW-1:0] rd_data, rdata;
    logic [NR*ZW-1:0] arsize;
    logic [NR*BW-1:0] arburst;
    logic [NW-1:0]    wr_req, wr_req_ack, wr_data_vld, wr_data_rdy, wr_cmpl;
    logic [NW-1:0]    awready, awvalid, wready, wvalid, wlast, bvalid, bready;
    logic [NW*IW-1:0] wr_req_id, awid;
    logic [NW*AW-1:0] wr_addr, awaddr;
    logic [NW*LW-1:0] wr_len, awlen;
    logic [NW*DW-1:0] wr_data, wdata;
    logic [NW*SW-1:0] wstrb;
    logic [NW*ZW-1:0] awsize;
    logic [NW*BW-1:0] awburst;

    // Slave model state
    logic          r_busy [NR];      // R burst in flight
    logic [LW-1:0] r_cnt [NR];       // Beat index on the bus
    logic [LW-1:0] r_len [NR];
    logic [DW-1:0] rd_seed_cur [NR]; // Seed of the open read from the client
    logic          b_pend [NW];      // B owed after wlast
    logic [NR-1:0] ar_hs_q, r_hs_q;  // Handshakes seen at the falling edge
    logic [NR*LW-1:0] arlen_q;
    logic [NW-1:0] wl_hs_q, b_hs_q;

    entry_t tbl [NE];
    int errs [NE+1];
    int seed = 32'h95234e14;
    int passed;
    int failed;
    int total_errs;

    cnn_axi_bridge #(.NUM_RD_CLIENTS(NR), .NUM_WR_CLIENTS(NW)) dut0 (.*);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk; // 100 ns period
    end

    function automatic logic random_bit();
        int r;
        r = $random(seed);
        return r[0];
    endfunction

    function automatic string slot_name(input int slot);
        return (slot == NE) ? "reset_idle" : tbl[slot].name;
    endfunction

    task automatic report_mismatch(input int slot, input string field,
                                   input logic [63:0] exp, input logic [63:0] act);
        $display("MISMATCH %s %s: expected %0h, actual %0h", slot_name(slot), field, exp, act);
        errs[slot]++;
    endtask

    task automatic report_timeout(input int slot, input string what);
        $display("Timeout in %s: no %s within %0d cycles", slot_name(slot), what, TIMEOUT);
        errs[slot]++;
    endtask

    task automatic finish_test(input int slot);
        $display("%s %s, %0d errors", (errs[slot] == 0) ? "PASS" : "FAIL", slot_name(slot),
                 errs[slot]);
    endtask

    ////////////////////////////////////////
    // Slave model for every master port
    ////////////////////////////////////////

    initial begin
        arready = '0;
        rvalid  = '0;
        rlast   = '0;
        rdata   = '0;
        awready = '0;
        wready  = '0;
        bvalid  = '0;
        for (int i = 0; i < NR; i++) begin
            r_busy[i] = 1'b0;
            r_cnt[i]  = '0;
            r_len[i]  = '0;
        end
        for (int j = 0; j < NW; j++) begin
            b_pend[j] = 1'b0;
        end
        forever begin
            @(negedge clk);              // Sample while stable
            ar_hs_q = arvalid & arready;
            r_hs_q  = rvalid & rready;
            arlen_q = arlen;
            wl_hs_q = wvalid & wready & wlast;
            b_hs_q  = bvalid & bready;
            @(posedge clk);
            #1;
            for (int i = 0; i < NR; i++) begin
                if (ar_hs_q[i]) begin
                    r_busy[i] = 1'b1;
                    r_cnt[i]  = '0;
                    r_len[i]  = arlen_q[i*LW +: LW];
                end else if (r_hs_q[i]) begin
                    if (r_cnt[i] == r_len[i]) begin
                        r_busy[i] = 1'b0; // Burst done
                    end else begin
                        r_cnt[i] = r_cnt[i] + 1'b1;
                    end
                end
                arready[i] = random_bit();  // Random stalls
                rvalid[i]  = r_busy[i];
                rlast[i]   = r_busy[i] && (r_cnt[i] == r_len[i]);
                rdata[i*DW +: DW] = rd_seed_cur[i] + 64'(r_cnt[i]);
            end
            for (int j = 0; j < NW; j++) begin
                if (wl_hs_q[j]) begin
                    b_pend[j] = 1'b1;
                end else if (b_hs_q[j]) begin
                    b_pend[j] = 1'b0;
                end
                awready[j] = random_bit();
                wready[j]  = random_bit();
                bvalid[j]  = b_pend[j];
            end
        end
    end

    ////////////////////////////////////////
    // Client side
    ////////////////////////////////////////

    task automatic run_read(input int idx);
        int c;
        int k;
        int t;
        logic hs;
        c = tbl[idx].client;
        @(posedge clk);
        #1;
        rd_seed_cur[c]        = tbl[idx].seed;
        rd_req[c]             = 1'b1;
        rd_req_id[c*IW +: IW] = tbl[idx].id;
        rd_addr[c*AW +: AW]   = tbl[idx].addr;
        rd_len[c*LW +: LW]    = tbl[idx].len;
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge clk);
            if (arvalid[c] !== 1'b1) report_mismatch(idx, "arvalid", 64'd1, 64'(arvalid[c]));
            if (rd_req_ack[c] !== arready[c]) begin
                report_mismatch(idx, "rd_req_ack", 64'(arready[c]), 64'(rd_req_ack[c]));
            end
            if (arready[c] === 1'b1) break;
            @(posedge clk);
        end
        if (t >= TIMEOUT) report_timeout(idx, "AR handshake");
        if (araddr[c*AW +: AW] !== tbl[idx].addr) begin
            report_mismatch(idx, "araddr", 64'(tbl[idx].addr), 64'(araddr[c*AW +: AW]));
        end
        if (arid[c*IW +: IW] !== tbl[idx].id) begin
            report_mismatch(idx, "arid", 64'(tbl[idx].id), 64'(arid[c*IW +: IW]));
        end
        if (arlen[c*LW +: LW] !== tbl[idx].len) begin
            report_mismatch(idx, "arlen", 64'(tbl[idx].len), 64'(arlen[c*LW +: LW]));
        end
        if (arsize[c*ZW +: ZW] !== axi_bridge_pkg::SIZE_BEAT) begin
            report_mismatch(idx, "arsize", 64'(axi_bridge_pkg::SIZE_BEAT), 64'(arsize[c*ZW +: ZW]));
        end
        if (arburst[c*BW +: BW] !== axi_bridge_pkg::BURST_INCR) begin
            report_mismatch(idx, "arburst", 64'(axi_bridge_pkg::BURST_INCR),
                            64'(arburst[c*BW +: BW]));
        end
        // rd_req stays high as a second request that must be held off
        k = 0;
        t = 0;
        while (k <= int'(tbl[idx].len) && t < TIMEOUT) begin
            @(posedge clk);
            #1;
            rd_data_rdy[c] = random_bit();
            @(negedge clk);
            if (arvalid[c] !== 1'b0) report_mismatch(idx, "arvalid while open", 64'd0, 64'd1);
            if (rd_data_vld[c] !== rvalid[c]) begin
                report_mismatch(idx, "rd_data_vld", 64'(rvalid[c]), 64'(rd_data_vld[c]));
            end
            if (rready[c] !== rd_data_rdy[c]) begin
                report_mismatch(idx, "rready", 64'(rd_data_rdy[c]), 64'(rready[c]));
            end
            hs = rvalid[c] && rd_data_rdy[c];
            if (rd_cmpl[c] !== (hs && k == int'(tbl[idx].len))) begin
                report_mismatch(idx, "rd_cmpl", 64'(hs && k == int'(tbl[idx].len)),
                                64'(rd_cmpl[c]));
            end
            if (hs) begin
                if (rd_data[c*DW +: DW] !== tbl[idx].seed + 64'(k)) begin
                    report_mismatch(idx, "rd_data", tbl[idx].seed + 64'(k), rd_data[c*DW +: DW]);
                end
                k++;
                t = 0;
            end else begin
                t++;
            end
        end
        if (t >= TIMEOUT) report_timeout(idx, "read beat");
        @(posedge clk);
        #1;
        rd_req[c]      = 1'b0;
        rd_data_rdy[c] = 1'b0;
    endtask

    task automatic run_write(input int idx);
        int c;
        int k;
        int t;
        logic hs;
        c = tbl[idx].client;
        @(posedge clk);
        #1;
        wr_req[c]             = 1'b1;
        wr_req_id[c*IW +: IW] = tbl[idx].id;
        wr_addr[c*AW +: AW]   = tbl[idx].addr;
        wr_len[c*LW +: LW]    = tbl[idx].len;
        wr_data_vld[c]        = 1'b1;            // First beat offered ahead of AW
        wr_data[c*DW +: DW]   = tbl[idx].seed;
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge clk);
            if (awvalid[c] !== 1'b1) report_mismatch(idx, "awvalid", 64'd1, 64'(awvalid[c]));
            if (wr_req_ack[c] !== awready[c]) begin
                report_mismatch(idx, "wr_req_ack", 64'(awready[c]), 64'(wr_req_ack[c]));
            end
            if (wvalid[c] !== 1'b0) report_mismatch(idx, "wvalid before AW", 64'd0, 64'd1);
            if (wr_data_rdy[c] !== 1'b0) begin
                report_mismatch(idx, "wr_data_rdy before AW", 64'd0, 64'd1);
            end
            if (awready[c] === 1'b1) break;
            @(posedge clk);
        end
        if (t >= TIMEOUT) report_timeout(idx, "AW handshake");
        if (awaddr[c*AW +: AW] !== tbl[idx].addr) begin
            report_mismatch(idx, "awaddr", 64'(tbl[idx].addr), 64'(awaddr[c*AW +: AW]));
        end
        if (awid[c*IW +: IW] !== tbl[idx].id) begin
            report_mismatch(idx, "awid", 64'(tbl[idx].id), 64'(awid[c*IW +: IW]));
        end
        if (awlen[c*LW +: LW] !== tbl[idx].len) begin
            report_mismatch(idx, "awlen", 64'(tbl[idx].len), 64'(awlen[c*LW +: LW]));
        end
        if (awsize[c*ZW +: ZW] !== axi_bridge_pkg::SIZE_BEAT) begin
            report_mismatch(idx, "awsize", 64'(axi_bridge_pkg::SIZE_BEAT), 64'(awsize[c*ZW +: ZW]));
        end
        if (awburst[c*BW +: BW] !== axi_bridge_pkg::BURST_INCR) begin
            report_mismatch(idx, "awburst", 64'(axi_bridge_pkg::BURST_INCR),
                            64'(awburst[c*BW +: BW]));
        end
        @(posedge clk);
        #1;
        wr_req[c] = 1'b0;
        k = 0;
        t = 0;
        while (k <= int'(tbl[idx].len) && t < TIMEOUT) begin
            @(negedge clk);
            hs = wr_data_vld[c] && wready[c];
            if (wvalid[c] !== 1'b1) report_mismatch(idx, "wvalid", 64'd1, 64'(wvalid[c]));
            if (wr_data_rdy[c] !== wready[c]) begin
                report_mismatch(idx, "wr_data_rdy", 64'(wready[c]), 64'(wr_data_rdy[c]));
            end
            if (wlast[c] !== (k == int'(tbl[idx].len))) begin
                report_mismatch(idx, "wlast", 64'(k == int'(tbl[idx].len)), 64'(wlast[c]));
            end
            if (hs) begin
                if (wdata[c*DW +: DW] !== tbl[idx].seed + 64'(k)) begin
                    report_mismatch(idx, "wdata", tbl[idx].seed + 64'(k), wdata[c*DW +: DW]);
                end
                if (wstrb[c*SW +: SW] !== {SW{1'b1}}) begin
                    report_mismatch(idx, "wstrb", 64'({SW{1'b1}}), 64'(wstrb[c*SW +: SW]));
                end
                k++;
                t = 0;
            end else begin
                t++;
            end
            @(posedge clk);
            #1;
            wr_data[c*DW +: DW] = tbl[idx].seed + 64'(k); // Next beat
        end
        if (t >= TIMEOUT) report_timeout(idx, "write beat");
        wr_data_vld[c] = 1'b0;
        for (t = 0; t < TIMEOUT; t++) begin
            @(negedge clk);
            if (bready[c] !== 1'b1) report_mismatch(idx, "bready", 64'd1, 64'(bready[c]));
            if (wr_cmpl[c] !== bvalid[c]) begin
                report_mismatch(idx, "wr_cmpl", 64'(bvalid[c]), 64'(wr_cmpl[c]));
            end
            if (wr_data_rdy[c] !== 1'b0) begin
                report_mismatch(idx, "wr_data_rdy in B phase", 64'd0, 64'd1);
            end
            if (bvalid[c] === 1'b1) break;
            @(posedge clk);
        end
        if (t >= TIMEOUT) report_timeout(idx, "B response");
        @(negedge clk);
        // Single pulse and port back in idle
        if (wr_cmpl[c] !== 1'b0) report_mismatch(idx, "wr_cmpl after B", 64'd0, 64'd1);
        if (bready[c] !== 1'b0) report_mismatch(idx, "bready after B", 64'd0, 64'd1);
    endtask

    // Walks the table for one client in entry order
    task automatic run_client(input logic is_wr, input int c);
        for (int i = 0; i < NE; i++) begin
            if (tbl[i].is_wr == is_wr && tbl[i].client == c) begin
                if (is_wr) begin
                    run_write(i);
                end else begin
                    run_read(i);
                end
                finish_test(i);
            end
        end
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////

    initial begin
        rst         = 1'b1;
        rd_req      = '0;
        rd_req_id   = '0;
        rd_addr     = '0;
        rd_len      = '0;
        rd_data_rdy = '0;
        wr_req      = '0;
        wr_req_id   = '0;
        wr_addr     = '0;
        wr_len      = '0;
        wr_data     = '0;
        wr_data_vld = '0;
        for (int i = 0; i < NR; i++) begin
            rd_seed_cur[i] = '0;
        end
        for (int i = 0; i <= NE; i++) begin
            errs[i] = 0;
        end
        //        name            wr    cl  id     addr           len    seed
        tbl[0] = '{"rd_c0_single", 1'b0, 0, 4'h1, 32'h0000_1000, 8'd0,  64'h1111_0000_0000_0100};
        tbl[1] = '{"rd_c0_burst8", 1'b0, 0, 4'h2, 32'h0000_2000, 8'd7,  64'h1111_2222_3333_0000};
        tbl[2] = '{"rd_c1_burst4", 1'b0, 1, 4'h3, 32'h0000_3000, 8'd3,  64'h2222_0000_0000_0200};
        tbl[3] = '{"rd_c1_burst16", 1'b0, 1, 4'h4, 32'h0000_4000, 8'd15, 64'h2222_4444_0000_FFF8};
        tbl[4] = '{"wr_c0_single", 1'b1, 0, 4'h5, 32'h0000_5000, 8'd0,  64'h5555_0000_0000_0500};
        tbl[5] = '{"wr_c0_burst8", 1'b1, 0, 4'h6, 32'h0000_6000, 8'd7,  64'h6666_0000_1234_0000};
        tbl[6] = '{"wr_c1_burst3", 1'b1, 1, 4'h7, 32'h0000_7000, 8'd2,  64'h7777_0000_0000_0700};
        tbl[7] = '{"wr_c1_burst32", 1'b1, 1, 4'h8, 32'h0000_8000, 8'd31, 64'h8888_ABCD_0000_0000};
        repeat (8) @(posedge clk);
        #1;
        rst         = 1'b0;
        wr_data_vld = '1;              // Offered in idle and kept off W
        @(negedge clk);
        if (arvalid !== '0) report_mismatch(NE, "arvalid", 64'd0, 64'(arvalid));
        if (awvalid !== '0) report_mismatch(NE, "awvalid", 64'd0, 64'(awvalid));
        if (wvalid !== '0) report_mismatch(NE, "wvalid", 64'd0, 64'(wvalid));
        if (wr_data_rdy !== '0) report_mismatch(NE, "wr_data_rdy", 64'd0, 64'(wr_data_rdy));
        if (bready !== '0) report_mismatch(NE, "bready", 64'd0, 64'(bready));
        if (wlast !== '0) report_mismatch(NE, "wlast", 64'd0, 64'(wlast));
        if (rd_cmpl !== '0) report_mismatch(NE, "rd_cmpl", 64'd0, 64'(rd_cmpl));
        if (wr_cmpl !== '0) report_mismatch(NE, "wr_cmpl", 64'd0, 64'(wr_cmpl));
        wr_data_vld = '0;
        finish_test(NE);
        fork                           // All clients at once
            run_client(1'b0, 0);
            run_client(1'b0, 1);
            run_client(1'b1, 0);
            run_client(1'b1, 1);
        join
        passed     = 0;
        failed     = 0;
        total_errs = 0;
        for (int i = 0; i <= NE; i++) begin
            if (errs[i] == 0) begin
                passed++;
            end else begin
                failed++;
            end
            total_errs += errs[i];
        end
        $display("Tests: %0d passed, %0d failed, %0d errors", passed, failed, total_errs);
        if (failed == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

// ==== cnn_axi_bridge.sv ====
`timescale 1ns/1ps

module cnn_axi_bridge #(
    parameter int NUM_RD_CLIENTS = 2,
    parameter int NUM_WR_CLIENTS = 2
) (
    input  logic                                   clk,
    input  logic                                   rst,
    ////////////////////////////////////////
    // Read clients
    ////////////////////////////////////////
    input  logic [NUM_RD_CLIENTS-1:0]                         rd_req,
    input  logic [NUM_RD_CLIENTS*axi_bridge_pkg::ID_W-1:0]    rd_req_id,
    input  logic [NUM_RD_CLIENTS*axi_bridge_pkg::ADDR_W-1:0]  rd_addr,
    input  logic [NUM_RD_CLIENTS*axi_bridge_pkg::LEN_W-1:0]   rd_len,
    output logic [NUM_RD_CLIENTS-1:0]                         rd_req_ack,
    output logic [NUM_RD_CLIENTS*axi_bridge_pkg::DATA_W-1:0]  rd_data,
    output logic [NUM_RD_CLIENTS-1:0]                         rd_data_vld,
    input  logic [NUM_RD_CLIENTS-1:0]                         rd_data_rdy,
    output logic [NUM_RD_CLIENTS-1:0]                         rd_cmpl,
    // AXI read masters
    input  logic [NUM_RD_CLIENTS-1:0]                         arready,
    output logic [NUM_RD_CLIENTS-1:0]                         arvalid,
    output logic [NUM_RD_CLIENTS*axi_bridge_pkg::ID_W-1:0]    arid,
    output logic [NUM_RD_CLIENTS*axi_bridge_pkg::ADDR_W-1:0]  araddr,
    output logic [NUM_RD_CLIENTS*axi_bridge_pkg::LEN_W-1:0]   arlen,
    output logic [NUM_RD_CLIENTS*axi_bridge_pkg::SIZE_W-1:0]  arsize,
    output logic [NUM_RD_CLIENTS*axi_bridge_pkg::BURST_W-1:0] arburst,
    input  logic [NUM_RD_CLIENTS*axi_bridge_pkg::DATA_W-1:0]  rdata,
    input  logic [NUM_RD_CLIENTS-1:0]                         rlast,
    input  logic [NUM_RD_CLIENTS-1:0]                         rvalid,
    output logic [NUM_RD_CLIENTS-1:0]                         rready,
    ////////////////////////////////////////
    // Write clients
    ////////////////////////////////////////
    input  logic [NUM_WR_CLIENTS-1:0]                         wr_req,
    input  logic [NUM_WR_CLIENTS*axi_bridge_pkg::ID_W-1:0]    wr_req_id,
    input  logic [NUM_WR_CLIENTS*axi_bridge_pkg::ADDR_W-1:0]  wr_addr,
    input  logic [NUM_WR_CLIENTS*axi_bridge_pkg::LEN_W-1:0]   wr_len,
    output logic [NUM_WR_CLIENTS-1:0]                         wr_req_ack,
    input  logic [NUM_WR_CLIENTS*axi_bridge_pkg::DATA_W-1:0]  wr_data,
    input  logic [NUM_WR_CLIENTS-1:0]                         wr_data_vld,
    output logic [NUM_WR_CLIENTS-1:0]                         wr_data_rdy,
    output logic [NUM_WR_CLIENTS-1:0]                         wr_cmpl,
    // AXI write masters
    input  logic [NUM_WR_CLIENTS-1:0]                         awready,
    output logic [NUM_WR_CLIENTS-1:0]                         awvalid,
    output logic [NUM_WR_CLIENTS*axi_bridge_pkg::ID_W-1:0]    awid,
    output logic [NUM_WR_CLIENTS*axi_bridge_pkg::ADDR_W-1:0]  awaddr,
    output logic [NUM_WR_CLIENTS*axi_bridge_pkg::LEN_W-1:0]   awlen,
    output logic [NUM_WR_CLIENTS*axi_bridge_pkg::SIZE_W-1:0]  awsize,
    output logic [NUM_WR_CLIENTS*axi_bridge_pkg::BURST_W-1:0] awburst,
    input  logic [NUM_WR_CLIENTS-1:0]                         wready,
    output logic [NUM_WR_CLIENTS-1:0]                         wvalid,
    output logic [NUM_WR_CLIENTS*axi_bridge_pkg::DATA_W-1:0]  wdata,
    output logic [NUM_WR_CLIENTS*axi_bridge_pkg::STRB_W-1:0]  wstrb,
    output logic [NUM_WR_CLIENTS-1:0]                         wlast,
    input  logic [NUM_WR_CLIENTS-1:0]                         bvalid,
    output logic [NUM_WR_CLIENTS-1:0]                         bready
);

    // Short names for slicing
    localparam int ID_W    = axi_bridge_pkg::ID_W;
    localparam int ADDR_W  = axi_bridge_pkg::ADDR_W;
    localparam int LEN_W   = axi_bridge_pkg::LEN_W;
    localparam int DATA_W  = axi_bridge_pkg::DATA_W;
    localparam int STRB_W  = axi_bridge_pkg::STRB_W;
    localparam int SIZE_W  = axi_bridge_pkg::SIZE_W;
    localparam int BURST_W = axi_bridge_pkg::BURST_W;

    // One read port per read client, slice i belongs to client i
    for (genvar i = 0; i < NUM_RD_CLIENTS; i++) begin : g_rd
        rd_port u_rd (
            .clk         (clk),
            .rst         (rst),
            .rd_req      (rd_req[i]),
            .rd_req_id   (rd_req_id[i*ID_W +: ID_W]),
            .rd_addr     (rd_addr[i*ADDR_W +: ADDR_W]),
            .rd_len      (rd_len[i*LEN_W +: LEN_W]),
            .rd_req_ack  (rd_req_ack[i]),
            .rd_data     (rd_data[i*DATA_W +: DATA_W]),
            .rd_data_vld (rd_data_vld[i]),
            .rd_data_rdy (rd_data_rdy[i]),
            .rd_cmpl     (rd_cmpl[i]),
            .arready     (arready[i]),
            .arvalid     (arvalid[i]),
            .arid        (arid[i*ID_W +: ID_W]),
            .araddr      (araddr[i*ADDR_W +: ADDR_W]),
            .arlen       (arlen[i*LEN_W +: LEN_W]),
            .arsize      (arsize[i*SIZE_W +: SIZE_W]),
            .arburst     (arburst[i*BURST_W +: BURST_W]),
            .rdata       (rdata[i*DATA_W +: DATA_W]),
            .rlast       (rlast[i]),
            .rvalid      (rvalid[i]),
            .rready      (rready[i])
        );
    end

    // Same layout on the write side
    for (genvar j = 0; j < NUM_WR_CLIENTS; j++) begin : g_wr
        wr_port u_wr (
            .clk         (clk),
            .rst         (rst),
            .wr_req      (wr_req[j]),
            .wr_req_id   (wr_req_id[j*ID_W +: ID_W]),
            .wr_addr     (wr_addr[j*ADDR_W +: ADDR_W]),
            .wr_len      (wr_len[j*LEN_W +: LEN_W]),
            .wr_req_ack  (wr_req_ack[j]),
            .wr_data     (wr_data[j*DATA_W +: DATA_W]),
            .wr_data_vld (wr_data_vld[j]),
            .wr_data_rdy (wr_data_rdy[j]),
            .wr_cmpl     (wr_cmpl[j]),
            .awready     (awready[j]),
            .awvalid     (awvalid[j]),
            .awid        (awid[j*ID_W +: ID_W]),
            .awaddr      (awaddr[j*ADDR_W +: ADDR_W]),
            .awlen       (awlen[j*LEN_W +: LEN_W]),
            .awsize      (awsize[j*SIZE_W +: SIZE_W]),
            .awburst     (awburst[j*BURST_W +: BURST_W]),
            .wready      (wready[j]),
            .wvalid      (wvalid[j]),
            .wdata       (wdata[j*DATA_W +: DATA_W]),
            .wstrb       (wstrb[j*STRB_W +: STRB_W]),
            .wlast       (wlast[j]),
            .bvalid      (bvalid[j]),
            .bready      (bready[j])
        );
    end

endmodule

// ==== wr_port.sv ====
`timescale 1ns/1ps

module wr_port (
    input  logic                                clk,
    input  logic                                rst,
    // Client request
    input  logic                                wr_req,
    input  logic [axi_bridge_pkg::ID_W-1:0]     wr_req_id,
    input  logic [axi_bridge_pkg::ADDR_W-1:0]   wr_addr,
    input  logic [axi_bridge_pkg::LEN_W-1:0]    wr_len,
    output logic                                wr_req_ack,
    // Client data and completion
    input  logic [axi_bridge_pkg::DATA_W-1:0]   wr_data,
    input  logic                                wr_data_vld,
    output logic                                wr_data_rdy,
    output logic                                wr_cmpl,
    // AXI write address channel
    input  logic                                awready,
    output logic                                awvalid,
    output logic [axi_bridge_pkg::ID_W-1:0]     awid,
    output logic [axi_bridge_pkg::ADDR_W-1:0]   awaddr,
    output logic [axi_bridge_pkg::LEN_W-1:0]    awlen,
    output logic [axi_bridge_pkg::SIZE_W-1:0]   awsize,
    output logic [axi_bridge_pkg::BURST_W-1:0]  awburst,
    // AXI write data channel
    input  logic                                wready,
    output logic                                wvalid,
    output logic [axi_bridge_pkg::DATA_W-1:0]   wdata,
    output logic [axi_bridge_pkg::STRB_W-1:0]   wstrb,
    output logic                                wlast,
    // AXI write response channel
    input  logic                                bvalid,
    output logic                                bready
);

    axi_bridge_pkg::wr_state_t phase;
    logic in_idle, in_data, in_resp; // Phase decodes
    logic w_xfer;                    // W beat moves this cycle
    logic last_beat;                 // Counter sits on beat AWLEN
    logic last_done;
    logic b_done;

    assign in_idle = (phase == axi_bridge_pkg::WR_IDLE);
    assign in_data = (phase == axi_bridge_pkg::WR_ADDR_DONE);
    assign in_resp = (phase == axi_bridge_pkg::WR_RESP);

    // AW only offered between bursts
    assign awvalid    = wr_req && in_idle;
    assign wr_req_ack = awvalid && awready;
    assign awid       = wr_req_id;
    assign awaddr     = wr_addr;
    assign awlen      = wr_len;
    assign awsize     = axi_bridge_pkg::SIZE_BEAT;
    assign awburst    = axi_bridge_pkg::BURST_INCR;

    ////////////////////////////////////////
    // W channel, open in data phase only
    ////////////////////////////////////////

    assign wvalid      = wr_data_vld && in_data;
    assign wr_data_rdy = wready && in_data;
    assign wdata       = wr_data;
    assign wstrb       = '1;                   // Full beats always
    assign wlast       = in_data && last_beat;
    assign w_xfer      = wvalid && wready;
    assign last_done   = w_xfer && wlast;

    // B channel, completion rides on bvalid
    assign bready  = in_resp;
    assign b_done  = bvalid && bready;
    assign wr_cmpl = bvalid && in_resp;

    wr_burst_fsm u_fsm (
        .clk       (clk),
        .rst       (rst),
        .aw_done   (wr_req_ack),
        .last_done (last_done),
        .b_done    (b_done),
        .phase     (phase)
    );

    beat_counter u_cnt (
        .clk       (clk),
        .rst       (rst),
        .load      (wr_req_ack), // Length latched with AW
        .len       (wr_len),
        .beat      (w_xfer),
        .last_beat (last_beat)
    );

endmodule

// ==== beat_counter.sv ====
`timescale 1ns/1ps

module beat_counter (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              load,  // New burst accepted
    input  logic [axi_bridge_pkg::LEN_W-1:0]  len,   // AWLEN of that burst
    input  logic                              beat,  // One W beat moved
    output logic                              last_beat
);

    logic [axi_bridge_pkg::LEN_W-1:0] len_q; // Latched AWLEN
    logic [axi_bridge_pkg::LEN_W-1:0] cnt;   // Beats sent so far

    // Count runs 0..len, so the final beat sees cnt == len
    assign last_beat = (cnt == len_q);

    always_ff @(posedge clk) begin
        if (rst) begin
            len_q <= '0;
            cnt   <= '0;
        end else if (load) begin
            len_q <= len;
            cnt   <= '0; // Fresh burst
        end else if (beat) begin
            cnt <= cnt + 1'b1;
        end
    end

endmodule

// ==== wr_burst_fsm.sv ====
`timescale 1ns/1ps

module wr_burst_fsm (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       aw_done,   // AW handshake this cycle
    input  logic                       last_done, // Beat with wlast transferred
    input  logic                       b_done,    // B handshake this cycle
    output axi_bridge_pkg::wr_state_t  phase
);

    axi_bridge_pkg::wr_state_t phase_nxt;

    ////////////////////////////////////////
    // Next phase
    ////////////////////////////////////////

    always_comb begin
        phase_nxt = phase; // Hold by default
        case (phase)
            axi_bridge_pkg::WR_IDLE: begin
                if (aw_done) begin
                    phase_nxt = axi_bridge_pkg::WR_ADDR_DONE;
                end
            end
            axi_bridge_pkg::WR_ADDR_DONE: begin
                // Stay here through W stalls
                if (last_done) begin
                    phase_nxt = axi_bridge_pkg::WR_RESP;
                end
            end
            axi_bridge_pkg::WR_RESP: begin
                if (b_done) begin
                    phase_nxt = axi_bridge_pkg::WR_IDLE;
                end
            end
            default: begin
                phase_nxt = axi_bridge_pkg::WR_IDLE; // Unused code, recover
            end
        endcase
    end

    ////////////////////////////////////////
    // Phase register
    ////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            phase <= axi_bridge_pkg::WR_IDLE;
        end else begin
            phase <= phase_nxt;
        end
    end

endmodule

// ==== rd_port.sv ====
`timescale 1ns/1ps

module rd_port (
    input  logic                                clk,
    input  logic                                rst,
    // Client request
    input  logic                                rd_req,
    input  logic [axi_bridge_pkg::ID_W-1:0]     rd_req_id,
    input  logic [axi_bridge_pkg::ADDR_W-1:0]   rd_addr,
    input  logic [axi_bridge_pkg::LEN_W-1:0]    rd_len,
    output logic                                rd_req_ack,
    // Client data return
    output logic [axi_bridge_pkg::DATA_W-1:0]   rd_data,
    output logic                                rd_data_vld,
    input  logic                                rd_data_rdy,
    output logic                                rd_cmpl,
    // AXI read address channel
    input  logic                                arready,
    output logic                                arvalid,
    output logic [axi_bridge_pkg::ID_W-1:0]     arid,
    output logic [axi_bridge_pkg::ADDR_W-1:0]   araddr,
    output logic [axi_bridge_pkg::LEN_W-1:0]    arlen,
    output logic [axi_bridge_pkg::SIZE_W-1:0]   arsize,
    output logic [axi_bridge_pkg::BURST_W-1:0]  arburst,
    // AXI read data channel
    input  logic [axi_bridge_pkg::DATA_W-1:0]   rdata,
    input  logic                                rlast,
    input  logic                                rvalid,
    output logic                                rready
);

    logic burst_open; // AR accepted, rlast not yet seen
    logic r_xfer;     // R beat moves this cycle

    // Request maps straight onto AR, blocked while a burst is open
    assign arvalid    = rd_req && !burst_open;
    assign rd_req_ack = arvalid && arready;
    assign arid       = rd_req_id;
    assign araddr     = rd_addr;
    assign arlen      = rd_len;
    assign arsize     = axi_bridge_pkg::SIZE_BEAT;
    assign arburst    = axi_bridge_pkg::BURST_INCR;

    // R pass-through, client owns rready
    assign rready      = rd_data_rdy;
    assign rd_data_vld = rvalid;
    assign rd_data     = rdata;

    assign r_xfer  = rvalid && rready;
    assign rd_cmpl = r_xfer && rlast; // One cycle, on the last beat

    always_ff @(posedge clk) begin
        if (rst) begin
            burst_open <= 1'b0;
        end else if (rd_req_ack) begin
            burst_open <= 1'b1;
        end else if (rd_cmpl) begin
            burst_open <= 1'b0; // Free for next request next cycle
        end
    end

endmodule

// ==== axi_bridge_pkg.sv ====
package axi_bridge_pkg;

    ////////////////////////////////////////
    // AXI field widths
    ////////////////////////////////////////

    localparam int ID_W    = 4;          // Transaction ID
    localparam int ADDR_W  = 32;         // Byte address
    localparam int LEN_W   = 8;          // AXLEN, beats minus one
    localparam int DATA_W  = 64;         // One beat of data
    localparam int STRB_W  = DATA_W / 8; // One strobe bit per byte
    localparam int SIZE_W  = 3;          // AXSIZE
    localparam int BURST_W = 2;          // AXBURST
    localparam int RESP_W  = 2;          // BRESP / RRESP

    ////////////////////////////////////////
    // Fixed burst codes
    ////////////////////////////////////////

    // Every transfer is an incrementing burst
    localparam logic [BURST_W-1:0] BURST_INCR = 2'b01;

    // 2**3 = 8 bytes per beat, matches DATA_W
    localparam logic [SIZE_W-1:0] SIZE_BEAT = 3'b011;

    ////////////////////////////////////////
    // Write burst phases
    ////////////////////////////////////////

    // Idle -> data phase after AW -> wait for B
    typedef enum logic [1:0] {
        WR_IDLE      = 2'd0, // Waiting for a client request
        WR_ADDR_DONE = 2'd1, // AW accepted, W beats flowing
        WR_RESP      = 2'd2  // Last beat sent, waiting on B
    } wr_state_t;

endpackage
